// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    // address and data bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // every transfer is a fixed incrementing burst
    localparam int burst_len = 16;

    // full-width beats, so one burst covers this many bytes
    localparam int burst_bytes = burst_len * data_width / 8;

    // byte address on AW and AR
    typedef logic [addr_width-1:0] axi_addr_t;

    // one bus word
    typedef logic [data_width-1:0] axi_data_t;

    // beat index inside a burst
    typedef logic [$clog2(burst_len)-1:0] beat_cnt_t;

    // write data channel
    typedef struct packed {
        axi_data_t data;
        logic      last;
    } axi_w_t;

    // read data channel
    typedef struct packed {
        axi_data_t data;
        logic      last;
    } axi_r_t;

endpackage

// ==== rtl/video_pkg.sv ====
package video_pkg;

    // active picture size
    localparam int frame_w = 16;
    localparam int frame_h = 8;

    // one pixel per 32-bit word in memory
    localparam int frame_bytes = frame_w * frame_h * 4;

    // bursts needed to move one whole frame
    localparam int bursts_per_frame = frame_bytes / axi_pkg::burst_bytes;

    // triple buffering
    localparam int buf_num = 3;

    // words held by each pixel FIFO
    localparam int fifo_depth = 64;

    // 8 bits per colour channel
    typedef logic [23:0] pixel_t;

    // frame buffer number, 0 to buf_num-1
    typedef logic [1:0] buf_idx_t;

    // incoming video levels
    typedef struct packed {
        logic   vs;
        logic   de;
        pixel_t data;
    } video_in_t;

endpackage

// ==== rtl/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo
    import axi_pkg::*;
#(
    parameter int depth = 64
) (
    input  logic                         M_AXI_ACLK,
    input  logic                         M_AXI_ARESETN,
    input  logic                         push,
    input  axi_data_t                    push_data,
    input  logic                         pop,
    output axi_data_t                    head,
    output logic [$clog2(depth+1)-1:0]   count
);

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic                     push_ok;
    logic                     pop_ok;

    // storage
    axi_data_t mem [depth];

    // push into a full FIFO is dropped
    assign push_ok = push && (count != depth);
    // pop from an empty FIFO is ignored
    assign pop_ok  = pop && (count != 0);

    // first word falls through
    assign head = mem[rd_ptr];

    always_ff @(posedge M_AXI_ACLK) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at depth
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/buffer_rotator.sv ====
`timescale 1ns/1ps

module buffer_rotator
    import axi_pkg::*, video_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      M_AXI_ARESETN,
    input  logic      vs,
    output logic      frame_done,
    output axi_addr_t wr_base,
    output axi_addr_t rd_base
);

    logic     vs_q;
    logic     vs_fall;
    buf_idx_t wr_idx;
    buf_idx_t done_idx;

    // vsync history for edge detect
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs;
        end
    end

    // high then low marks the end of a frame
    assign vs_fall = vs_q && !vs;

    // one-cycle pulse, lines up with the new indices
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= vs_fall;
        end
    end

    // write buffer steps 0, 1, 2, 0
    // the buffer just filled becomes the one to read
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_idx   <= '0;
            done_idx <= '0;
        end else if (vs_fall) begin
            done_idx <= wr_idx;
            wr_idx   <= (wr_idx == buf_num - 1) ? '0 : wr_idx + 1'b1;
        end
    end

    // buffer index to byte base
    assign wr_base = axi_addr_t'(wr_idx) * frame_bytes;
    assign rd_base = axi_addr_t'(done_idx) * frame_bytes;

endmodule

// ==== rtl/frame_write_engine.sv ====
`timescale 1ns/1ps

module frame_write_engine
    import axi_pkg::*, video_pkg::*;
(
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  logic [$clog2(fifo_depth+1)-1:0]   fifo_count,
    input  axi_data_t                         fifo_head,
    output logic                              fifo_pop,
    input  logic                              frame_done,
    input  axi_addr_t                         wr_base,
    output axi_addr_t                         awaddr,
    output logic                              awvalid,
    input  logic                              awready,
    output axi_w_t                            w,
    output logic                              wvalid,
    input  logic                              wready
);

    logic      burst_active;
    logic      burst_req;
    logic      aw_fire;
    logic      w_fire;
    logic      wlast;
    beat_cnt_t beat_cnt;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // a whole burst must be waiting in the input FIFO
    assign burst_req = !burst_active && (fifo_count >= burst_len);

    // each accepted beat consumes the FIFO head
    assign fifo_pop = w_fire;
    assign w        = '{data: fifo_head, last: wlast};

    // set on request, cleared by the last beat
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            burst_active <= 1'b0;
        end else if (w_fire && wlast) begin
            burst_active <= 1'b0;
        end else if (burst_req) begin
            burst_active <= 1'b1;
        end
    end

    // address phase
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            awvalid <= 1'b0;
        end else if (aw_fire) begin
            awvalid <= 1'b0;
        end else if (burst_req) begin
            awvalid <= 1'b1;
        end
    end

    // new frame restarts at the current write buffer
    // otherwise step one burst per accepted address
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            awaddr <= '0;
        end else if (frame_done) begin
            awaddr <= wr_base;
        end else if (aw_fire) begin
            awaddr <= awaddr + burst_bytes;
        end
    end

    // data phase opens after the address is taken
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wvalid <= 1'b0;
        end else if (w_fire && wlast) begin
            wvalid <= 1'b0;
        end else if (aw_fire) begin
            wvalid <= 1'b1;
        end
    end

    // beat index, wraps back to 0 after beat 16
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= wlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // raised ahead of the final beat
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wlast <= 1'b0;
        end else if (w_fire && wlast) begin
            wlast <= 1'b0;
        end else if (w_fire && beat_cnt == burst_len - 2) begin
            wlast <= 1'b1;
        end
    end

endmodule

// ==== rtl/frame_read_engine.sv ====
`timescale 1ns/1ps

module frame_read_engine
    import axi_pkg::*, video_pkg::*;
(
    input  logic                              M_AXI_ACLK,
    input  logic                              M_AXI_ARESETN,
    input  logic                              frame_done,
    input  axi_addr_t                         rd_base,
    input  logic [$clog2(fifo_depth+1)-1:0]   fifo_count,
    output logic                              fifo_push,
    output axi_addr_t                         araddr,
    output logic                              arvalid,
    input  logic                              arready,
    input  axi_r_t                            r,
    input  logic                              rvalid,
    output logic                              rready,
    output logic                              post_start
);

    // nothing to read until one frame is in memory
    typedef enum logic {
        st_idle,
        st_run
    } rd_state_t;

    rd_state_t                             state;
    logic                                  burst_active;
    logic                                  burst_req;
    logic                                  ar_fire;
    logic                                  r_fire;
    logic                                  burst_done;
    logic                                  frame_wrap;
    logic [$clog2(bursts_per_frame)-1:0]   burst_cnt;

    assign ar_fire    = arvalid && arready;
    assign r_fire     = rvalid && rready;
    assign burst_done = r_fire && r.last;
    // last beat of the last burst in the frame
    assign frame_wrap = burst_done && (burst_cnt == bursts_per_frame - 1);

    // room for a full burst in the output FIFO
    assign burst_req = (state == st_run) && !burst_active
                       && (fifo_count <= fifo_depth - burst_len);

    // every accepted beat goes straight into the output FIFO
    assign fifo_push = r_fire;

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state <= st_idle;
        end else if (state == st_idle && frame_done) begin
            state <= st_run;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            burst_active <= 1'b0;
        end else if (burst_done) begin
            burst_active <= 1'b0;
        end else if (burst_req) begin
            burst_active <= 1'b1;
        end
    end

    // address phase
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            arvalid <= 1'b0;
        end else if (ar_fire) begin
            arvalid <= 1'b0;
        end else if (burst_req) begin
            arvalid <= 1'b1;
        end
    end

    // first frame and every wrap pick up the latest finished buffer
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            araddr <= '0;
        end else if (state == st_idle && frame_done) begin
            araddr <= rd_base;
        end else if (frame_wrap) begin
            araddr <= rd_base;
        end else if (ar_fire) begin
            araddr <= araddr + burst_bytes;
        end
    end

    // bursts completed in the current frame
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            burst_cnt <= '0;
        end else if (frame_wrap) begin
            burst_cnt <= '0;
        end else if (burst_done) begin
            burst_cnt <= burst_cnt + 1'b1;
        end
    end

    // data phase
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            rready <= 1'b0;
        end else if (burst_done) begin
            rready <= 1'b0;
        end else if (ar_fire) begin
            rready <= 1'b1;
        end
    end

    // sticky once a burst worth of pixels is buffered
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            post_start <= 1'b0;
        end else if (state == st_run && fifo_count >= burst_len) begin
            post_start <= 1'b1;
        end
    end

endmodule

// ==== rtl/frame_buffer_dma.sv ====
`timescale 1ns/1ps

module frame_buffer_dma
    import axi_pkg::*, video_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      M_AXI_ARESETN,
    input  video_in_t video_in,
    input  logic      post_de,
    output axi_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    output axi_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output logic      post_start,
    output pixel_t    post_data
);

    logic [$clog2(fifo_depth+1)-1:0] in_count;
    logic [$clog2(fifo_depth+1)-1:0] out_count;
    axi_data_t                       in_word;
    axi_data_t                       in_head;
    axi_data_t                       out_head;
    logic                            in_pop;
    logic                            out_push;
    logic                            out_pop;
    logic                            frame_done;
    axi_addr_t                       wr_base;
    axi_addr_t                       rd_base;

    // pixel padded to a bus word
    assign in_word = {{(data_width - $bits(pixel_t)){1'b0}}, video_in.data};

    // sink pops only once output has started
    assign out_pop   = post_de && post_start;
    assign post_data = out_head[$bits(pixel_t)-1:0];

    // video in to write engine
    pixel_fifo #(
        .depth (fifo_depth)
    ) u_in_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .push          (video_in.de),
        .push_data     (in_word),
        .pop           (in_pop),
        .head          (in_head),
        .count         (in_count)
    );

    // read engine to video out
    pixel_fifo #(
        .depth (fifo_depth)
    ) u_out_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .push          (out_push),
        .push_data     (r.data),
        .pop           (out_pop),
        .head          (out_head),
        .count         (out_count)
    );

    buffer_rotator u_rotator (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .vs            (video_in.vs),
        .frame_done    (frame_done),
        .wr_base       (wr_base),
        .rd_base       (rd_base)
    );

    frame_write_engine u_write (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .fifo_count    (in_count),
        .fifo_head     (in_head),
        .fifo_pop      (in_pop),
        .frame_done    (frame_done),
        .wr_base       (wr_base),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready)
    );

    frame_read_engine u_read (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .frame_done    (frame_done),
        .rd_base       (rd_base),
        .fifo_count    (out_count),
        .fifo_push     (out_push),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .post_start    (post_start)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic M_AXI_ACLK,
    output logic M_AXI_ARESETN
);

    // 4 ns period
    initial begin
        M_AXI_ACLK = 1'b0;
        forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // two cycles in reset, released on a falling edge
    initial begin
        M_AXI_ARESETN = 1'b0;
        repeat (2) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b1;
    end

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model
    import axi_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      M_AXI_ARESETN,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_w_t    w,
    input  logic      wvalid,
    output logic      wready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_r_t    r,
    output logic      rvalid,
    input  logic      rready,
    output int        wr_words
);

    // three frame buffers of 512 bytes
    localparam int mem_words = 1536 / 4;

    axi_data_t   mem [mem_words];
    logic [31:0] rnd;
    logic        aw_busy;
    logic        ar_busy;
    logic        r_taken;
    axi_addr_t   wr_ptr;
    axi_addr_t   rd_ptr;
    int          rd_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // true about one draw in four
    function automatic logic stall(input logic [31:0] s);
        return s[31:30] == 2'b00;
    endfunction

    initial begin
        // fill from the byte address so stale reads stand out
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = axi_data_t'(~(i * 4));
        end
        rnd      = 32'hc7638f2b;
        awready  = 1'b0;
        wready   = 1'b0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        r        = '0;
        aw_busy  = 1'b0;
        ar_busy  = 1'b0;
        r_taken  = 1'b0;
        wr_ptr   = '0;
        rd_ptr   = '0;
        rd_left  = 0;
        wr_words = 0;
    end

    // handshakes complete on the rising edge
    always @(posedge M_AXI_ACLK) begin
        r_taken = 1'b0;
        if (!M_AXI_ARESETN) begin
            aw_busy  = 1'b0;
            ar_busy  = 1'b0;
            wr_words = 0;
        end else begin
            // one write burst at a time
            if (awvalid && awready) begin
                wr_ptr  = awaddr;
                aw_busy = 1'b1;
            end
            if (wvalid && wready) begin
                mem[wr_ptr >> 2] = w.data;
                wr_ptr = wr_ptr + 4;
                wr_words++;
                if (w.last) begin
                    aw_busy = 1'b0;
                end
            end
            // one read burst at a time
            if (arvalid && arready) begin
                rd_ptr  = araddr;
                rd_left = burst_len;
                ar_busy = 1'b1;
            end
            if (rvalid && rready) begin
                rd_ptr = rd_ptr + 4;
                rd_left--;
                r_taken = 1'b1;
                if (rd_left == 0) begin
                    ar_busy = 1'b0;
                end
            end
        end
    end

    // slave outputs move on the falling edge
    always @(negedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
        end else begin
            rnd     = lcg_next(rnd);
            awready = !aw_busy && !stall(rnd);
            rnd     = lcg_next(rnd);
            wready  = aw_busy && !stall(rnd);
            rnd     = lcg_next(rnd);
            arready = !ar_busy && !stall(rnd);
            // a beat on offer stays until taken
            if (!(rvalid && !r_taken)) begin
                rnd    = lcg_next(rnd);
                rvalid = ar_busy && !stall(rnd);
            end
            r = '{data: mem[rd_ptr >> 2], last: rd_left == 1};
        end
    end

endmodule

// ==== verif/frame_buffer_dma_tb.sv ====
`timescale 1ns/1ps

module frame_buffer_dma_tb
    import axi_pkg::*, video_pkg::*;
();

    localparam int frame_pixels   = frame_w * frame_h;
    localparam int frames_total   = 4;
    localparam int hblank         = 32;
    localparam int timeout_cycles = 4 * frame_pixels * 20;

    logic        M_AXI_ACLK;
    logic        M_AXI_ARESETN;
    video_in_t   video_in;
    logic        post_de;
    axi_addr_t   awaddr;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_addr_t   araddr;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    logic        post_start;
    pixel_t      post_data;
    int          wr_words;

    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          aw_cnt = 0;
    int          w_cnt = 0;
    int          ar_cnt = 0;
    int          r_beats = 0;
    int          r_bursts = 0;
    logic [31:0] rnd = 32'hc7638f2b;
    // buffer rotation mirror driven from vsync
    logic        vs_prev = 1'b0;
    logic        reading = 1'b0;
    buf_idx_t    wr_buf = '0;
    buf_idx_t    done_buf = '0;
    axi_addr_t   next_araddr = '0;
    // which frame each buffer holds
    int          buf_frame [buf_num] = '{default: 0};
    int          popped [frames_total] = '{default: 0};
    pixel_t      exp_pixels [$];
    int          exp_frames [$];

    tb_clock u_clock (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN)
    );

    frame_buffer_dma uut (.*);
    axi_mem_model u_mem (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected pixel hashed from frame number and position
    function automatic pixel_t ref_pixel(input int frame, input int idx);
        logic [31:0] h;
        h = 32'hc7638f2b ^ (frame << 12) ^ idx;
        h = lcg_next(h);
        h = lcg_next(h ^ (h >> 15));
        return h[31:8];
    endfunction

    task automatic compare_addr(input string name, input axi_addr_t got,
                                input axi_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_data(input string name, input axi_data_t got,
                                input axi_data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // active lines with blanking, then vsync once memory holds the frame
    task automatic send_frame(input int frame);
        for (int y = 0; y < frame_h; y++) begin
            for (int x = 0; x < frame_w; x++) begin
                @(negedge M_AXI_ACLK);
                video_in.de   = 1'b1;
                video_in.data = ref_pixel(frame, y * frame_w + x);
            end
            @(negedge M_AXI_ACLK);
            video_in.de   = 1'b0;
            video_in.data = '0;
            repeat (hblank) @(negedge M_AXI_ACLK);
        end
        while (wr_words < (frame + 1) * frame_pixels) begin
            @(negedge M_AXI_ACLK);
        end
        video_in.vs = 1'b1;
        repeat (4) @(negedge M_AXI_ACLK);
        // falling edge closes the frame
        video_in.vs = 1'b0;
        buf_frame[frame % buf_num] = frame;
        repeat (4) @(negedge M_AXI_ACLK);
    endtask

    // sink asks for a pixel about one cycle in four
    always @(negedge M_AXI_ACLK) begin
        rnd     = lcg_next(rnd);
        post_de = M_AXI_ARESETN && rnd[31:30] == 2'b00;
    end

    // samples before the edge updates anything
    always @(posedge M_AXI_ACLK) begin : check_bus
        int b;
        int first;
        if (M_AXI_ARESETN) begin
            if (post_de && post_start) begin
                if (exp_pixels.size() == 0) begin
                    other_errors++;
                    $display("%0t: pixel popped while no read data was expected", $time);
                end else begin
                    compare_pixel("post_data", post_data, exp_pixels.pop_front());
                    popped[exp_frames.pop_front()]++;
                end
            end
            if (post_start && r_beats < burst_len) begin
                other_errors++;
                $display("%0t: post_start is high before a full burst was read", $time);
            end
            // k-th burst of frame f lands in buffer f mod 3
            if (awvalid && awready) begin
                compare_addr("awaddr", awaddr,
                    axi_addr_t'((aw_cnt / bursts_per_frame) % buf_num * frame_bytes
                                + aw_cnt % bursts_per_frame * burst_bytes));
                aw_cnt++;
            end
            if (wvalid && wready) begin
                compare_data("w.data", w.data,
                    axi_data_t'(ref_pixel(w_cnt / frame_pixels, w_cnt % frame_pixels)));
                compare_flag("w.last", w.last, w_cnt % burst_len == burst_len - 1);
                w_cnt++;
            end
            // queue the pixels this burst must deliver
            if (arvalid && arready) begin
                compare_addr("araddr", araddr, next_araddr);
                b     = next_araddr / frame_bytes;
                first = next_araddr % frame_bytes / 4;
                for (int j = 0; j < burst_len; j++) begin
                    exp_pixels.push_back(ref_pixel(buf_frame[b], first + j));
                    exp_frames.push_back(buf_frame[b]);
                end
                next_araddr = next_araddr + burst_bytes;
                ar_cnt++;
            end
            if (rvalid && rready) begin
                r_beats++;
                if (r.last) begin
                    r_bursts++;
                    // whole frame read, restart at the newest finished buffer
                    if (r_bursts % bursts_per_frame == 0) begin
                        next_araddr = done_buf * frame_bytes;
                    end
                end
            end
            if (vs_prev && !video_in.vs) begin
                if (!reading) begin
                    next_araddr = wr_buf * frame_bytes;
                end
                reading  = 1'b1;
                done_buf = wr_buf;
                wr_buf   = (wr_buf == buf_num - 1) ? '0 : wr_buf + 1'b1;
            end
            vs_prev = video_in.vs;
        end
    end

    always @(posedge M_AXI_ACLK) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        video_in = '0;
        post_de  = 1'b0;
        @(posedge M_AXI_ARESETN);
        @(negedge M_AXI_ACLK);
        // all channels idle out of reset
        compare_flag("awvalid", awvalid, 1'b0);
        compare_flag("wvalid", wvalid, 1'b0);
        compare_flag("arvalid", arvalid, 1'b0);
        compare_flag("rready", rready, 1'b0);
        compare_flag("post_start", post_start, 1'b0);
        send_frame(0);
        // reader goes once through frame 0 and wraps
        while (ar_cnt <= bursts_per_frame) begin
            @(negedge M_AXI_ACLK);
        end
        // the fourth frame brings the write buffer back to 0
        for (int f = 1; f < frames_total; f++) begin
            send_frame(f);
            while (popped[f] < frame_pixels) begin
                @(negedge M_AXI_ACLK);
            end
        end
        if (wr_words != frames_total * frame_pixels) begin
            other_errors++;
            $display("memory took %0d words, expected %0d", wr_words,
                     frames_total * frame_pixels);
        end
        // the newest three frames sit whole in their buffers
        for (int f = frames_total - buf_num; f < frames_total; f++) begin
            for (int i = 0; i < frame_pixels; i++) begin
                compare_data("stored word", u_mem.mem[(f % buf_num) * frame_pixels + i],
                             axi_data_t'(ref_pixel(f, i)));
            end
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== frame_buffer_dma.f ====
rtl/axi_pkg.sv
rtl/video_pkg.sv
rtl/pixel_fifo.sv
rtl/buffer_rotator.sv
rtl/frame_write_engine.sv
rtl/frame_read_engine.sv
rtl/frame_buffer_dma.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/frame_buffer_dma_tb.sv
